//--- verilog/erx_pkg.sv
package erx_pkg;

   //##########################################################################
   // link and packet fields
   //##########################################################################

   typedef logic [15:0]  word_t;      // one captured word per rx_lclk edge
   typedef logic [31:0]  addr_t;      // mesh address
   typedef logic [31:0]  data_t;      // data word
   typedef logic [1:0]   datamode_t;  // 0 byte, 1 half, 2 word, 3 double
   typedef logic [3:0]   ctrlmode_t;  // passed along untouched

   // seven link words of one frame, word 0 in the low slot
   typedef logic [111:0] sample_t;

   // 104 bit mesh packet, srcaddr at the top
   typedef struct packed {
      addr_t     srcaddr;             // [103:72]
      data_t     data;                // [71:40]
      addr_t     dstaddr;             // [39:8]
      ctrlmode_t ctrlmode;            // [7:4]
      datamode_t datamode;            // [3:2]
      logic      write;               // [1]
      logic      access;              // [0]
   } emesh_packet_t;

   //##########################################################################
   // queue and burst constants
   //##########################################################################

   localparam int FIFO_DEPTH = 8;     // queued packets
   localparam int FIFO_AW    = 3;     // pointer width, 2**FIFO_AW == FIFO_DEPTH
   localparam int WAIT_LEVEL = 6;     // pushback threshold
   localparam int BURST_STEP = 8;     // dstaddr step between burst packets

   //##########################################################################
   // bus master states
   //##########################################################################

   typedef enum logic [1:0] {
      IDLE,                           // waiting for a queued packet
      BUS,                            // cycle on the bus until ack
      RESP                            // read data held for the response stage
   } wb_state_t;

endpackage

//--- verilog/erx_frame_decode.sv
`timescale 1ns/10ps

module erx_frame_decode
   import erx_pkg::*;
(
   input  logic          rx_lclk,
   input  logic          reset,
   input  word_t         rx_word,
   input  logic          rx_frame,
   output logic          dec_valid,
   output emesh_packet_t dec_packet
);

   logic [6:0]    word_ptr;      // one-hot slot select
   sample_t       sample;        // raw frame words
   logic          access;        // seventh word just landed
   logic          access_d;      // fields are in the stage register
   logic          burst_detect;  // a packet already left this frame
   logic          burst_stage;   // burst flag travelling with the stage
   emesh_packet_t shuffled;      // sample rearranged into packet order
   emesh_packet_t pkt_stage;     // first packet register
   addr_t         next_dst;

   //##########################################################################
   // word pointer and sample register
   //##########################################################################

   always_ff @(posedge rx_lclk or posedge reset)
   begin
      if (reset)
         word_ptr <= 7'b0000001;
      else if (!rx_frame)
         word_ptr <= 7'b0000001;          // idle link, next word is slot 0
      else if (word_ptr[6])
         word_ptr <= 7'b0001000;          // burst continues at slot 3
      else
         word_ptr <= {word_ptr[5:0], 1'b0};
   end

   // only the slot under the pointer takes the word
   always_ff @(posedge rx_lclk)
   begin
      if (rx_frame)
      begin
         for (int i = 0; i < 7; i++)
            if (word_ptr[i])
               sample[16*i +: 16] <= rx_word;
      end
   end

   //##########################################################################
   // strobes
   //##########################################################################

   always_ff @(posedge rx_lclk or posedge reset)
   begin
      if (reset)
      begin
         access       <= 1'b0;
         access_d     <= 1'b0;
         dec_valid    <= 1'b0;
         burst_detect <= 1'b0;
      end
      else
      begin
         access    <= word_ptr[6] & rx_frame;   // last word of a group
         access_d  <= access;
         dec_valid <= access_d;
         if (access & rx_frame)
            burst_detect <= 1'b1;               // frame still running
         else if (!rx_frame)
            burst_detect <= 1'b0;
      end
   end

   //##########################################################################
   // field shuffle
   //##########################################################################

   // bytes arrive low first, byte n sits at sample[8n+7:8n]
   always_comb
   begin
      shuffled.access   = sample[40];
      shuffled.write    = sample[41];
      shuffled.datamode = sample[43:42];
      shuffled.ctrlmode = sample[15:12];
      shuffled.dstaddr  = {sample[11:8],        // byte 1 low nibble
                           sample[23:16],       // byte 2
                           sample[31:24],       // byte 3
                           sample[39:32],       // byte 4
                           sample[47:44]};      // byte 5 high nibble
      shuffled.data     = {sample[55:48], sample[63:56],
                           sample[71:64], sample[79:72]};
      shuffled.srcaddr  = {sample[87:80], sample[95:88],
                           sample[103:96], sample[111:104]};
   end

   // slot 3 is overwritten one cycle after access in a burst, so grab now
   always_ff @(posedge rx_lclk)
   begin
      if (access)
      begin
         pkt_stage   <= shuffled;
         burst_stage <= burst_detect;
      end
   end

   // burst packets walk on from the previous destination
   assign next_dst = burst_stage ? dec_packet.dstaddr + addr_t'(BURST_STEP)
                                 : pkt_stage.dstaddr;

   always_ff @(posedge rx_lclk)
   begin
      if (access_d)
      begin
         dec_packet         <= pkt_stage;
         dec_packet.dstaddr <= next_dst;
      end
   end

endmodule

//--- verilog/erx_packet_fifo.sv
`timescale 1ns/10ps

module erx_packet_fifo
   import erx_pkg::*;
(
   input  logic          rx_lclk,
   input  logic          reset,
   input  logic          dec_valid,
   input  emesh_packet_t dec_packet,
   output logic          q_valid,
   input  logic          q_ready,
   output emesh_packet_t q_packet,
   output logic          wr_wait,
   output logic          rd_wait
);

   emesh_packet_t      mem [FIFO_DEPTH];
   logic [FIFO_AW-1:0] wr_ptr;
   logic [FIFO_AW-1:0] rd_ptr;
   logic [FIFO_AW:0]   count;        // 0 to FIFO_DEPTH
   logic               full;
   logic               above;        // at or over the wait level
   logic               head_write;   // kind of the oldest entry
   logic               wr_en;
   logic               rd_en;

   assign full    = (count == (FIFO_AW+1)'(FIFO_DEPTH));
   assign above   = (count >= (FIFO_AW+1)'(WAIT_LEVEL));
   assign wr_en   = dec_valid & ~full;      // strobe into a full queue is lost
   assign rd_en   = q_valid & q_ready;

   assign q_valid  = (count != '0);
   assign q_packet = mem[rd_ptr];
   assign head_write = q_packet.write;

   //##########################################################################
   // storage and pointers
   //##########################################################################

   always_ff @(posedge rx_lclk)
   begin
      if (wr_en)
         mem[wr_ptr] <= dec_packet;
   end

   always_ff @(posedge rx_lclk or posedge reset)
   begin
      if (reset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (wr_en)
            wr_ptr <= wr_ptr + 1'b1;    // wraps at FIFO_DEPTH
         if (rd_en)
            rd_ptr <= rd_ptr + 1'b1;
         case ({wr_en, rd_en})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;    // none or both
         endcase
      end
   end

   //##########################################################################
   // pushback to the sender
   //##########################################################################

   always_ff @(posedge rx_lclk or posedge reset)
   begin
      if (reset)
      begin
         wr_wait <= 1'b0;
         rd_wait <= 1'b0;
      end
      else
      begin
         wr_wait <= full | (above & head_write);   // full stops both
         rd_wait <= full | (above & ~head_write);
      end
   end

endmodule

//--- verilog/erx_wb_master.sv
`timescale 1ns/10ps

module erx_wb_master
   import erx_pkg::*;
(
   input  logic          rx_lclk,
   input  logic          reset,
   input  logic          q_valid,
   output logic          q_ready,
   input  emesh_packet_t q_packet,
   output logic          wb_cyc,
   output logic          wb_stb,
   output logic          wb_we,
   output addr_t         wb_adr,
   output logic [3:0]    wb_sel,
   output data_t         wb_dat_w,
   input  data_t         wb_dat_r,
   input  logic          wb_ack,
   input  logic          resp_busy,
   output logic          rd_done,
   output emesh_packet_t rd_packet
);

   wb_state_t     state;
   emesh_packet_t req;        // packet on the bus
   data_t         rd_data;    // read data, already shifted down

   //##########################################################################
   // byte lanes
   //##########################################################################

   function automatic logic [3:0] lane_sel(input datamode_t mode,
                                           input logic [1:0] lsb);
      logic [3:0] sel;
      case (mode)
         2'd0:    sel = 4'b0001 << lsb;                  // one byte
         2'd1:    sel = lsb[1] ? 4'b1100 : 4'b0011;      // upper or lower half
         default: sel = 4'b1111;                         // word and double
      endcase
      return sel;
   endfunction

   // copy the low bits across every lane, the select picks the right one
   function automatic data_t lane_write(input datamode_t mode, input data_t dat);
      data_t placed;
      case (mode)
         2'd0:    placed = {4{dat[7:0]}};
         2'd1:    placed = {2{dat[15:0]}};
         default: placed = dat;
      endcase
      return placed;
   endfunction

   function automatic data_t lane_read(input datamode_t mode,
                                       input logic [1:0] lsb,
                                       input data_t dat);
      data_t shifted;
      data_t result;
      shifted = dat >> {lsb, 3'b000};
      case (mode)
         2'd0:    result = {24'd0, shifted[7:0]};
         2'd1:    result = {16'd0, lsb[1] ? dat[31:16] : dat[15:0]};
         default: result = dat;
      endcase
      return result;
   endfunction

   //##########################################################################
   // state machine
   //##########################################################################

   always_ff @(posedge rx_lclk or posedge reset)
   begin
      if (reset)
         state <= IDLE;
      else
      begin
         case (state)
            IDLE:    if (q_valid) state <= BUS;                 // take one packet
            BUS:     if (wb_ack) state <= req.write ? IDLE : RESP;
            RESP:    if (!resp_busy) state <= IDLE;             // handed over
            default: state <= IDLE;
         endcase
      end
   end

   always_ff @(posedge rx_lclk)
   begin
      if (q_valid & q_ready)
         req <= q_packet;
      if ((state == BUS) & wb_ack & ~req.write)
         rd_data <= lane_read(req.datamode, req.dstaddr[1:0], wb_dat_r);
   end

   assign q_ready = (state == IDLE);

   // bus outputs come straight from req so they hold while stb is up
   assign wb_cyc   = (state == BUS);
   assign wb_stb   = (state == BUS);
   assign wb_we    = req.write;
   assign wb_adr   = req.dstaddr;
   assign wb_sel   = lane_sel(req.datamode, req.dstaddr[1:0]);
   assign wb_dat_w = lane_write(req.datamode, req.data);

   assign rd_done = (state == RESP) & ~resp_busy;   // single cycle, leaves RESP

   always_comb
   begin
      rd_packet      = req;
      rd_packet.data = rd_data;
   end

endmodule

//--- verilog/erx_read_return.sv
`timescale 1ns/10ps

module erx_read_return
   import erx_pkg::*;
(
   input  logic          rx_lclk,
   input  logic          reset,
   input  logic          rd_done,
   input  emesh_packet_t rd_packet,
   output logic          resp_busy,
   output logic          resp_valid,
   input  logic          resp_ready,
   output emesh_packet_t resp_packet
);

   emesh_packet_t wb_resp;    // write-back built from the read request

   // reply goes back to the requester, carrying the read data
   always_comb
   begin
      wb_resp          = rd_packet;
      wb_resp.dstaddr  = rd_packet.srcaddr;
      wb_resp.srcaddr  = rd_packet.dstaddr;
      wb_resp.write    = 1'b1;
      wb_resp.access   = 1'b1;
   end

   always_ff @(posedge rx_lclk or posedge reset)
   begin
      if (reset)
         resp_valid <= 1'b0;
      else if (rd_done)
         resp_valid <= 1'b1;               // master only sends when empty
      else if (resp_ready)
         resp_valid <= 1'b0;               // taken by the sink
   end

   always_ff @(posedge rx_lclk)
   begin
      if (rd_done)
         resp_packet <= wb_resp;           // held until accepted
   end

   assign resp_busy = resp_valid;

endmodule

//--- verilog/erx_top.sv
`timescale 1ns/10ps

module erx_top
   import erx_pkg::*;
(
   input  logic          rx_lclk,
   input  logic          reset,
   input  word_t         rx_word,
   input  logic          rx_frame,
   output logic          wr_wait,
   output logic          rd_wait,
   output logic          wb_cyc,
   output logic          wb_stb,
   output logic          wb_we,
   output addr_t         wb_adr,
   output logic [3:0]    wb_sel,
   output data_t         wb_dat_w,
   input  data_t         wb_dat_r,
   input  logic          wb_ack,
   output logic          resp_valid,
   input  logic          resp_ready,
   output emesh_packet_t resp_packet
);

   logic          dec_valid;     // decode strobe into the queue
   emesh_packet_t dec_packet;
   logic          q_valid;       // queue head to bus master
   logic          q_ready;
   emesh_packet_t q_packet;
   logic          rd_done;       // finished read to response stage
   emesh_packet_t rd_packet;
   logic          resp_busy;

   //##########################################################################
   // frame decode, queue, bus, response
   //##########################################################################

   erx_frame_decode u_decode (
      .rx_lclk    (rx_lclk),
      .reset      (reset),
      .rx_word    (rx_word),
      .rx_frame   (rx_frame),
      .dec_valid  (dec_valid),
      .dec_packet (dec_packet)
   );

   erx_packet_fifo u_fifo (
      .rx_lclk    (rx_lclk),
      .reset      (reset),
      .dec_valid  (dec_valid),
      .dec_packet (dec_packet),
      .q_valid    (q_valid),
      .q_ready    (q_ready),
      .q_packet   (q_packet),
      .wr_wait    (wr_wait),
      .rd_wait    (rd_wait)
   );

   erx_wb_master u_wb (
      .rx_lclk    (rx_lclk),
      .reset      (reset),
      .q_valid    (q_valid),
      .q_ready    (q_ready),
      .q_packet   (q_packet),
      .wb_cyc     (wb_cyc),
      .wb_stb     (wb_stb),
      .wb_we      (wb_we),
      .wb_adr     (wb_adr),
      .wb_sel     (wb_sel),
      .wb_dat_w   (wb_dat_w),
      .wb_dat_r   (wb_dat_r),
      .wb_ack     (wb_ack),
      .resp_busy  (resp_busy),
      .rd_done    (rd_done),
      .rd_packet  (rd_packet)
   );

   erx_read_return u_resp (
      .rx_lclk     (rx_lclk),
      .reset       (reset),
      .rd_done     (rd_done),
      .rd_packet   (rd_packet),
      .resp_busy   (resp_busy),
      .resp_valid  (resp_valid),
      .resp_ready  (resp_ready),
      .resp_packet (resp_packet)
   );

endmodule

//--- test/tb_wb_mem.sv
`timescale 1ns/10ps

module tb_wb_mem
   import erx_pkg::*;
(
   input  logic       rx_lclk,
   input  logic       reset,
   input  logic       wb_cyc,
   input  logic       wb_stb,
   input  logic       wb_we,
   input  addr_t      wb_adr,
   input  logic [3:0] wb_sel,
   input  data_t      wb_dat_w,
   output data_t      wb_dat_r,
   output logic       wb_ack,
   input  logic [1:0] ack_delay    // extra wait cycles, changes every cycle
);

   data_t      mem [256];
   logic [1:0] wait_cnt;
   logic [7:0] idx;

   assign idx = wb_adr[9:2];       // word index

   // every word differs from its neighbours
   initial
   begin
      for (int i = 0; i < 256; i++)
         mem[i] = {i[7:0], ~i[7:0], i[7:0] ^ 8'ha5, 8'h3c};
   end

   always_ff @(posedge rx_lclk or posedge reset)
   begin
      if (reset)
      begin
         wb_ack   <= 1'b0;
         wait_cnt <= '0;
      end
      else
      begin
         wb_ack <= 1'b0;
         if (wb_cyc && wb_stb && !wb_ack)
         begin
            if (wait_cnt >= ack_delay)
            begin
               wb_ack   <= 1'b1;
               wait_cnt <= '0;
               wb_dat_r <= mem[idx];
               if (wb_we)
                  for (int j = 0; j < 4; j++)
                     if (wb_sel[j])
                        mem[idx][8*j +: 8] <= wb_dat_w[8*j +: 8];  // lane merge
            end
            else
               wait_cnt <= wait_cnt + 1'b1;
         end
      end
   end

endmodule

//--- test/tb_erx.sv
`timescale 1ns/10ps

module tb_erx;
   import erx_pkg::*;

   logic          rx_lclk;
   logic          reset;
   word_t         rx_word;
   logic          rx_frame;
   logic          wr_wait, rd_wait;
   logic          wb_cyc, wb_stb, wb_we, wb_ack;
   addr_t         wb_adr;
   logic [3:0]    wb_sel;
   data_t         wb_dat_w, wb_dat_r;
   logic          resp_valid, resp_ready;
   emesh_packet_t resp_packet;
   logic [1:0]    ack_delay;

   logic [31:0]   lfsr;
   logic          hold_resp;     // forces resp_ready low
   logic          started;       // first frame on the link
   int            reads_sent;
   int            resp_count;
   data_t         shadow [256];  // expected memory contents
   emesh_packet_t bus_q[$];      // packets still to appear on the bus
   emesh_packet_t resp_q[$];     // responses still to come out

   erx_top UUT (.*);

   tb_wb_mem MEM (.*);

   //##########################################################################
   // clock, random bits, failure reporting
   //##########################################################################

   initial
   begin
      rx_lclk = 1'b0;
      forever #10 rx_lclk = ~rx_lclk;
   end

   // taps 32 22 2 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic rand_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         lfsr = lfsr_next(lfsr);
         v    = {v[30:0], lfsr[0]};   // one step per bit
      end
   endtask

   task automatic value_fail(input string name, input logic [103:0] got,
                             input logic [103:0] exp);
      $display("ERR t=%0t %s got %h expected %h", $time, name, got, exp);
      $display("sim failed");
      $fatal(1, "value check");
   endtask

   task automatic plain_fail(input string what);
      $display("t=%0t %s", $time, what);
      $display("sim failed");
      $fatal(1, "protocol check");
   endtask

   //##########################################################################
   // expected values from the lane rules
   //##########################################################################

   function automatic logic [3:0] select_mask(input emesh_packet_t p);
      logic [3:0] s;
      for (int j = 0; j < 4; j++)
         case (p.datamode)
            2'd0:    s[j] = (j == int'(p.dstaddr[1:0]));
            2'd1:    s[j] = ((j / 2) == int'(p.dstaddr[1]));
            default: s[j] = 1'b1;
         endcase
      return s;
   endfunction

   function automatic logic [7:0] lane_byte(input emesh_packet_t p, input int j);
      if (p.datamode == 2'd0)
         return p.data[7:0];
      else if (p.datamode == 2'd1)
         return p.data[8*(j%2) +: 8];
      return p.data[8*j +: 8];
   endfunction

   function automatic data_t shifted_read(input emesh_packet_t p, input data_t w);
      if (p.datamode == 2'd0)
         return {24'd0, w[8*p.dstaddr[1:0] +: 8]};
      else if (p.datamode == 2'd1)
         return {16'd0, w[16*int'(p.dstaddr[1]) +: 16]};
      return w;
   endfunction

   // byte n of the frame sits at [8n+7:8n]
   function automatic logic [111:0] frame_bytes(input emesh_packet_t p);
      logic [111:0] v;
      v[7:0]     = 8'h00;
      v[15:8]    = {p.ctrlmode, p.dstaddr[31:28]};
      v[23:16]   = p.dstaddr[27:20];
      v[31:24]   = p.dstaddr[19:12];
      v[39:32]   = p.dstaddr[11:4];
      v[47:40]   = {p.dstaddr[3:0], p.datamode, p.write, p.access};
      for (int k = 0; k < 4; k++)
      begin
         v[48+8*k +: 8] = p.data[31-8*k -: 8];     // msb first
         v[80+8*k +: 8] = p.srcaddr[31-8*k -: 8];
      end
      return v;
   endfunction

   function automatic emesh_packet_t make_pkt(input addr_t dst, input data_t dat,
                                              input datamode_t dm, input logic wr);
      emesh_packet_t p;
      p.srcaddr  = {16'h5eed, dst[15:0]};
      p.data     = dat;
      p.dstaddr  = dst;
      p.ctrlmode = dst[5:2];
      p.datamode = dm;
      p.write    = wr;
      p.access   = 1'b1;
      return p;
   endfunction

   //##########################################################################
   // frame driver
   //##########################################################################

   task automatic send_frame(input emesh_packet_t p, input int extra);
      logic [111:0]  v;
      emesh_packet_t cur;
      int            t;
      t = 0;
      while (wr_wait || rd_wait)
      begin
         @(posedge rx_lclk);
         t++;
         if (t > 4000)
            plain_fail("timeout waiting for wr_wait and rd_wait to drop");
      end
      started <= 1'b1;
      cur = p;
      v   = frame_bytes(cur);
      for (int w = 0; w < 7; w++)
      begin
         @(posedge rx_lclk);
         rx_frame <= 1'b1;
         rx_word  <= v[16*w +: 16];
      end
      bus_q.push_back(cur);
      if (!cur.write)
         reads_sent++;
      for (int k = 1; k <= extra; k++)
      begin
         cur.dstaddr = cur.dstaddr + BURST_STEP;
         cur.data    = cur.data + 32'h0101_0101;
         cur.srcaddr = cur.srcaddr + 4;
         v = frame_bytes(cur);
         for (int w = 3; w < 7; w++)     // data and srcaddr only
         begin
            @(posedge rx_lclk);
            rx_word <= v[16*w +: 16];
         end
         bus_q.push_back(cur);
      end
      @(posedge rx_lclk);
      rx_frame <= 1'b0;
      repeat (5) @(posedge rx_lclk);   // lets pushback settle
   endtask

   task automatic drain(input string what);
      int t;
      t = 0;
      while (bus_q.size() != 0 || resp_q.size() != 0)
      begin
         @(posedge rx_lclk);
         t++;
         if (t > 8000)
            plain_fail({"timeout draining after ", what});
      end
   endtask

   //##########################################################################
   // monitors and assertions
   //##########################################################################

   always @(posedge rx_lclk)
   begin
      logic [31:0] v;
      rand_bits(2, v);
      ack_delay <= v[1:0];
      rand_bits(1, v);
      resp_ready <= hold_resp ? 1'b0 : v[0];
   end

   // nothing moves before the first frame
   always @(posedge rx_lclk)
      if (!reset && !started)
      begin
         assert ({wb_cyc, wb_stb, wr_wait, rd_wait, resp_valid, UUT.dec_valid,
                  UUT.q_valid, UUT.rd_done} == '0)
         else plain_fail("control output high before the first frame");
      end

   assert property (@(posedge rx_lclk) disable iff (reset)
                    (wb_cyc && !wb_ack) |=> (wb_stb && $stable(wb_adr)
                    && $stable(wb_we) && $stable(wb_sel)))
   else plain_fail("wb_stb dropped or bus outputs changed before wb_ack");

   always @(posedge rx_lclk)
   begin
      emesh_packet_t e;
      emesh_packet_t r;
      logic [3:0]    sel;
      logic [7:0]    idx;
      if (!reset && wb_cyc && wb_stb && wb_ack)
      begin
         if (bus_q.size() == 0)
            plain_fail("bus cycle with no packet sent");
         e   = bus_q.pop_front();
         sel = select_mask(e);
         idx = e.dstaddr[9:2];
         assert (wb_adr == e.dstaddr) else value_fail("wb_adr", wb_adr, e.dstaddr);
         assert (wb_we == e.write) else value_fail("wb_we", wb_we, e.write);
         assert (wb_sel == sel) else value_fail("wb_sel", wb_sel, sel);
         if (e.write)
         begin
            for (int j = 0; j < 4; j++)
               if (sel[j])
               begin
                  assert (wb_dat_w[8*j +: 8] == lane_byte(e, j))
                  else value_fail("wb_dat_w", wb_dat_w[8*j +: 8], lane_byte(e, j));
                  shadow[idx][8*j +: 8] = lane_byte(e, j);
               end
            assert (MEM.mem[idx] == shadow[idx])
            else value_fail("mem", MEM.mem[idx], shadow[idx]);
         end
         else
         begin
            r         = e;                 // reply goes back to the sender
            r.dstaddr = e.srcaddr;
            r.srcaddr = e.dstaddr;
            r.write   = 1'b1;
            r.access  = 1'b1;
            r.data    = shifted_read(e, shadow[idx]);
            resp_q.push_back(r);
         end
      end
   end

   always @(posedge rx_lclk)
   begin
      emesh_packet_t e;
      if (!reset && resp_valid && resp_ready)
      begin
         if (resp_q.size() == 0)
            plain_fail("response with no read outstanding");
         e = resp_q.pop_front();
         assert (resp_packet == e) else value_fail("resp_packet", resp_packet, e);
         resp_count++;
      end
   end

   //##########################################################################
   // stimulus
   //##########################################################################

   initial
   begin
      int t;
      lfsr       = 32'h4ceb;
      reset      = 1'b1;
      rx_word    = '0;
      rx_frame   = 1'b0;
      resp_ready = 1'b0;
      ack_delay  = '0;
      hold_resp  = 1'b0;
      started    = 1'b0;
      reads_sent = 0;
      resp_count = 0;
      for (int i = 0; i < 256; i++)
         shadow[i] = {i[7:0], ~i[7:0], i[7:0] ^ 8'ha5, 8'h3c};
      repeat (4) @(posedge rx_lclk);
      reset <= 1'b0;
      repeat (6) @(posedge rx_lclk);

      // single writes of each size
      send_frame(make_pkt(32'h7a00_0040, 32'hdead_beef, 2'd2, 1'b1), 0);
      send_frame(make_pkt(32'h7a00_0045, 32'h0000_00a7, 2'd0, 1'b1), 0);
      send_frame(make_pkt(32'h7a00_004a, 32'h0000_c0de, 2'd1, 1'b1), 0);
      send_frame(make_pkt(32'h7a00_0053, 32'h1357_9bdf, 2'd3, 1'b1), 0);
      drain("writes");

      // reads of each size over written and untouched words
      send_frame(make_pkt(32'h7a00_0045, 32'h0, 2'd0, 1'b0), 0);
      send_frame(make_pkt(32'h7a00_004a, 32'h0, 2'd1, 1'b0), 0);
      send_frame(make_pkt(32'h7a00_0040, 32'h0, 2'd2, 1'b0), 0);
      send_frame(make_pkt(32'h7a00_0053, 32'h0, 2'd3, 1'b0), 0);
      send_frame(make_pkt(32'h0000_0083, 32'h0, 2'd0, 1'b0), 0);
      drain("reads");

      // burst of four writes and their read back
      send_frame(make_pkt(32'h0000_0100, 32'h1020_3040, 2'd2, 1'b1), 3);
      for (int k = 0; k < 4; k++)
         send_frame(make_pkt(32'h0000_0100 + 8*k, 32'h0, 2'd2, 1'b0), 0);
      drain("burst");

      // stalled responses fill the queue
      hold_resp <= 1'b1;
      for (int k = 0; k < 8; k++)
         send_frame(make_pkt(32'h0000_0200 + 4*k, 32'h0, 2'd2, 1'b0), 0);
      t = 0;
      while (!rd_wait)
      begin
         @(posedge rx_lclk);
         t++;
         if (t > 500)
            plain_fail("rd_wait never rose with responses held");
      end
      hold_resp <= 1'b0;
      drain("held reads");
      repeat (10) @(posedge rx_lclk);

      if (resp_count != reads_sent || resp_q.size() != 0 || bus_q.size() != 0)
      begin
         $display("response count %0d, reads sent %0d", resp_count, reads_sent);
         $display("sim failed");
         $fatal(1, "count mismatch");
      end
      else
      begin
         $display("sim passed");
         $finish;
      end
   end

endmodule

//--- src.f
verilog/erx_pkg.sv
verilog/erx_frame_decode.sv
verilog/erx_packet_fifo.sv
verilog/erx_wb_master.sv
verilog/erx_read_return.sv
verilog/erx_top.sv
test/tb_wb_mem.sv
test/tb_erx.sv

//--- run_sim.sh
#!/bin/sh
# build and run the erx testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f src.f --top-module tb_erx \
   -o tb_erx_sim > build.log 2>&1
if [ $? -ne 0 ]; then
   echo "verilator build failed, see build.log"
   exit 1
fi

./obj_dir/tb_erx_sim > "$LOG" 2>&1
run_status=$?

if grep -q "sim failed" "$LOG"; then
   echo "simulation reported failure, see $LOG"
   exit 1
fi

if [ $run_status -ne 0 ]; then
   echo "simulation exited with status $run_status, see $LOG"
   exit 1
fi

echo "simulation finished, see $LOG"
exit 0
